// File: design/scsi_dp_pkg.sv
package scsi_dp_pkg;

    // scsi data bus width, one byte per request
    localparam int BYTE_W = 8;

    // host and fifo word width
    localparam int WORD_W = 32;

    // bytes carried in one host word
    localparam int LANES = WORD_W / BYTE_W;

    // lane index, lane 0 is bits [31:24] and lane 3 is bits [7:0]
    typedef logic [$clog2(LANES)-1:0] lane_t;

    // last lane of a word, after it the word is complete or released
    localparam lane_t LANE_LAST = lane_t'(LANES - 1);

    // transfer direction, driven by the dma control logic
    // F2S   fifo to scsi, word unpacked byte by byte
    // S2F   scsi to fifo, bytes packed into words
    // CPU2S direct cpu write of one byte to scsi
    // S2CPU direct cpu read of one latched scsi byte
    typedef enum logic [2:0] {
        XM_IDLE  = 3'd0,
        XM_F2S   = 3'd1,
        XM_S2F   = 3'd2,
        XM_CPU2S = 3'd3,
        XM_S2CPU = 3'd4
    } xfer_mode_t;

endpackage

// File: design/dma_word_fifo.sv
`timescale 1ns/1ps

module dma_word_fifo #(
    // number of words, a power of two from 2 up
    parameter int DEPTH = 8
) (
    input  logic                           LS2CPU,
    input  logic                           rst,
    // write side
    input  logic                           push,
    input  logic [scsi_dp_pkg::WORD_W-1:0] push_data,
    // read side, head shows the oldest word while not empty
    input  logic                           pop,
    output logic [scsi_dp_pkg::WORD_W-1:0] head,
    // status flags
    output logic                           empty,
    output logic                           full
);

    // address width of the storage array
    localparam int AW = $clog2(DEPTH);

    // word storage
    logic [scsi_dp_pkg::WORD_W-1:0] mem [DEPTH];

    // pointers carry one extra wrap bit
    // equal pointers mean empty, only the wrap bit differing means full
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    // qualified strobes
    logic do_push;
    logic do_pop;

    // a push into a full buffer or a pop from an empty one is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // status from pointer compare
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // show-ahead read, the head word needs no read strobe
    assign head = mem[rd_ptr[AW-1:0]];

    // pointer update
    always_ff @(posedge LS2CPU) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage write, next free slot
    always_ff @(posedge LS2CPU) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    // senders check full before they strobe, there is no back-pressure
    a_no_overflow: assert property (
        @(posedge LS2CPU) disable iff (rst)
        push |-> !full
    ) else $error("word fifo push while full");

    // readers check empty before they strobe
    a_no_underflow: assert property (
        @(posedge LS2CPU) disable iff (rst)
        pop |-> !empty
    ) else $error("word fifo pop while empty");

    // a word pushed into an empty buffer shows on head in the next cycle
    a_push_to_head: assert property (
        @(posedge LS2CPU) disable iff (rst)
        (push && empty && !pop) |=> (!empty && head == $past(push_data))
    ) else $error("pushed word did not reach head");

endmodule

// File: design/scsi_byte_unpacker.sv
`timescale 1ns/1ps

module scsi_byte_unpacker (
    input  logic                           LS2CPU,
    input  logic                           rst,
    input  scsi_dp_pkg::xfer_mode_t        mode,
    // f2s fifo read side
    input  logic [scsi_dp_pkg::WORD_W-1:0] f2s_head,
    input  logic                           f2s_empty,
    output logic                           f2s_pop,
    // byte request from the scsi bus
    input  logic                           scsi_req,
    // direct cpu write
    input  logic                           cpu_wr,
    input  logic [scsi_dp_pkg::WORD_W-1:0] cpu_wdata,
    input  logic                           a3,
    // scsi transmit side
    output logic                           tx_ready,
    output logic [scsi_dp_pkg::BYTE_W-1:0] scsi_dout,
    output logic                           scsi_dout_valid
);

    // held word and its lane position
    logic [scsi_dp_pkg::WORD_W-1:0] word_q;
    logic                           have_word;
    scsi_dp_pkg::lane_t             lane;

    // mode decode
    logic f2s_mode;
    logic cpu_mode;

    // byte transfer strobes
    logic f2s_fire;
    logic cpu_fire;

    // one-hot byte selects, four word lanes plus two cpu lanes
    logic [scsi_dp_pkg::LANES-1:0] lane_sel;
    logic                          cpu_sel_lo;
    logic                          cpu_sel_hi;

    // byte picked for the next scsi transfer
    logic [scsi_dp_pkg::BYTE_W-1:0] tx_byte;

    assign f2s_mode = (mode == scsi_dp_pkg::XM_F2S);
    assign cpu_mode = (mode == scsi_dp_pkg::XM_CPU2S);

    // load a word as soon as the holding register is free
    assign f2s_pop  = f2s_mode && !have_word && !f2s_empty;
    assign tx_ready = have_word;

    assign f2s_fire = f2s_mode && have_word && scsi_req;
    assign cpu_fire = cpu_mode && cpu_wr;

    // 2-to-4 lane decoder, enabled in f2s only
    always_comb begin
        lane_sel = '0;
        if (f2s_mode) begin
            lane_sel[lane] = 1'b1;
        end
    end

    // cpu byte lane from address bit a3
    assign cpu_sel_lo = cpu_mode && !a3;
    assign cpu_sel_hi = cpu_mode && a3;

    // byte mux, at most one select is active
    always_comb begin
        tx_byte = '0;
        for (int i = 0; i < scsi_dp_pkg::LANES; i++) begin
            if (lane_sel[i]) begin
                tx_byte = word_q[scsi_dp_pkg::WORD_W-1-i*scsi_dp_pkg::BYTE_W -: scsi_dp_pkg::BYTE_W];
            end
        end
        if (cpu_sel_lo) begin
            tx_byte = cpu_wdata[7:0];
        end
        if (cpu_sel_hi) begin
            tx_byte = cpu_wdata[23:16];
        end
    end

    // holding state and lane counter
    always_ff @(posedge LS2CPU) begin
        if (rst) begin
            have_word       <= 1'b0;
            lane            <= '0;
            scsi_dout_valid <= 1'b0;
        end else begin
            scsi_dout_valid <= f2s_fire || cpu_fire;
            if (!f2s_mode) begin
                // leaving f2s drops the held word and restarts at lane 0
                have_word <= 1'b0;
                lane      <= '0;
            end else if (f2s_pop) begin
                have_word <= 1'b1;
                lane      <= '0;
            end else if (f2s_fire) begin
                // counter wraps to 0 after the last lane
                lane <= lane + 1'b1;
                if (lane == scsi_dp_pkg::LANE_LAST) begin
                    have_word <= 1'b0;
                end
            end
        end
    end

    // payload registers
    always_ff @(posedge LS2CPU) begin
        if (f2s_pop) begin
            word_q <= f2s_head;
        end
        if (f2s_fire || cpu_fire) begin
            scsi_dout <= tx_byte;
        end
    end

    // the scsi side only asks for a byte once a word is loaded
    a_req_needs_ready: assert property (
        @(posedge LS2CPU) disable iff (rst)
        (f2s_mode && scsi_req) |-> tx_ready
    ) else $error("scsi_req in F2S without tx_ready");

endmodule

// File: design/scsi_byte_packer.sv
`timescale 1ns/1ps

module scsi_byte_packer (
    input  logic                           LS2CPU,
    input  logic                           rst,
    input  scsi_dp_pkg::xfer_mode_t        mode,
    // byte strobe and data from the scsi bus
    input  logic                           scsi_req,
    input  logic [scsi_dp_pkg::BYTE_W-1:0] scsi_din,
    // s2f fifo write side
    output logic                           s2f_push,
    output logic [scsi_dp_pkg::WORD_W-1:0] s2f_word,
    // direct cpu read pattern
    output logic [scsi_dp_pkg::WORD_W-1:0] cpu_rdata
);

    // word under assembly and its lane position
    logic [scsi_dp_pkg::WORD_W-1:0] word_q;
    scsi_dp_pkg::lane_t             lane;

    // last byte seen in s2cpu
    logic [scsi_dp_pkg::BYTE_W-1:0] cpu_byte;

    // mode decode
    logic s2f_mode;
    logic cpu_mode;

    // byte capture strobes
    logic s2f_fire;
    logic cpu_fire;

    assign s2f_mode = (mode == scsi_dp_pkg::XM_S2F);
    assign cpu_mode = (mode == scsi_dp_pkg::XM_S2CPU);

    assign s2f_fire = s2f_mode && scsi_req;
    assign cpu_fire = cpu_mode && scsi_req;

    // control state
    always_ff @(posedge LS2CPU) begin
        if (rst) begin
            lane     <= '0;
            s2f_push <= 1'b0;
            cpu_byte <= '0;
        end else begin
            // push one cycle after the byte that fills the last lane
            s2f_push <= s2f_fire && (lane == scsi_dp_pkg::LANE_LAST);
            if (!s2f_mode) begin
                // a partial word is dropped on a mode change
                lane <= '0;
            end else if (s2f_fire) begin
                lane <= lane + 1'b1;
            end
            if (cpu_fire) begin
                cpu_byte <= scsi_din;
            end
        end
    end

    // byte placement, first byte lands in [31:24]
    always_ff @(posedge LS2CPU) begin
        if (s2f_fire) begin
            word_q[scsi_dp_pkg::WORD_W-1-int'(lane)*scsi_dp_pkg::BYTE_W -: scsi_dp_pkg::BYTE_W]
                <= scsi_din;
        end
    end

    // word is complete while s2f_push is high
    // a new byte in the same cycle only lands after the fifo has taken it
    assign s2f_word = word_q;

    // byte in the upper lane of each halfword, zero below
    assign cpu_rdata = {cpu_byte, {scsi_dp_pkg::BYTE_W{1'b0}},
                        cpu_byte, {scsi_dp_pkg::BYTE_W{1'b0}}};

    // the dma control leaves S2F only between words
    a_lane_idle: assert property (
        @(posedge LS2CPU) disable iff (rst)
        !s2f_mode |-> (lane == '0)
    ) else $error("packer lane counter not zero outside S2F");

endmodule

// File: design/scsi_datapath.sv
`timescale 1ns/1ps

module scsi_datapath #(
    // words per fifo, passed to both fifos
    parameter int FIFO_DEPTH = 8
) (
    input  logic                           LS2CPU,
    input  logic                           rst,
    input  scsi_dp_pkg::xfer_mode_t        mode,
    // host write into the f2s fifo
    input  logic                           host_wr,
    input  logic [scsi_dp_pkg::WORD_W-1:0] host_wdata,
    output logic                           f2s_full,
    output logic                           f2s_empty,
    // host read from the s2f fifo
    input  logic                           host_rd,
    output logic [scsi_dp_pkg::WORD_W-1:0] host_rdata,
    output logic                           s2f_empty,
    output logic                           s2f_full,
    // scsi data bus, split in and out
    input  logic                           scsi_req,
    input  logic [scsi_dp_pkg::BYTE_W-1:0] scsi_din,
    output logic [scsi_dp_pkg::BYTE_W-1:0] scsi_dout,
    output logic                           scsi_dout_valid,
    output logic                           scsi_oe,
    output logic                           tx_ready,
    // direct cpu access
    input  logic                           cpu_wr,
    input  logic [scsi_dp_pkg::WORD_W-1:0] cpu_wdata,
    input  logic                           a3,
    output logic [scsi_dp_pkg::WORD_W-1:0] cpu_rdata
);

    // f2s fifo to unpacker
    logic [scsi_dp_pkg::WORD_W-1:0] f2s_head;
    logic                           f2s_pop;

    // packer to s2f fifo
    logic                           s2f_push;
    logic [scsi_dp_pkg::WORD_W-1:0] s2f_word;

    // scsi bus is driven in the two outbound modes
    assign scsi_oe = (mode == scsi_dp_pkg::XM_F2S) || (mode == scsi_dp_pkg::XM_CPU2S);

    // host to scsi word buffer
    dma_word_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) f2s_fifo_i (
        .LS2CPU    (LS2CPU),
        .rst       (rst),
        .push      (host_wr),
        .push_data (host_wdata),
        .pop       (f2s_pop),
        .head      (f2s_head),
        .empty     (f2s_empty),
        .full      (f2s_full)
    );

    // word to byte, plus the cpu write byte path
    scsi_byte_unpacker unpacker_i (
        .LS2CPU          (LS2CPU),
        .rst             (rst),
        .mode            (mode),
        .f2s_head        (f2s_head),
        .f2s_empty       (f2s_empty),
        .f2s_pop         (f2s_pop),
        .scsi_req        (scsi_req),
        .cpu_wr          (cpu_wr),
        .cpu_wdata       (cpu_wdata),
        .a3              (a3),
        .tx_ready        (tx_ready),
        .scsi_dout       (scsi_dout),
        .scsi_dout_valid (scsi_dout_valid)
    );

    // byte to word, plus the cpu read latch
    scsi_byte_packer packer_i (
        .LS2CPU    (LS2CPU),
        .rst       (rst),
        .mode      (mode),
        .scsi_req  (scsi_req),
        .scsi_din  (scsi_din),
        .s2f_push  (s2f_push),
        .s2f_word  (s2f_word),
        .cpu_rdata (cpu_rdata)
    );

    // scsi to host word buffer, host reads the head directly
    dma_word_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) s2f_fifo_i (
        .LS2CPU    (LS2CPU),
        .rst       (rst),
        .push      (s2f_push),
        .push_data (s2f_word),
        .pop       (host_rd),
        .head      (host_rdata),
        .empty     (s2f_empty),
        .full      (s2f_full)
    );

endmodule

// File: sim/tb_scsi_datapath.sv
`timescale 1ns/1ps

module tb_scsi_datapath;

    localparam int FIFO_DEPTH = 8;
    // cycle limit for any single wait loop
    localparam int WAIT_LIMIT = 200;
    // number of mode phases in the interleaved run
    localparam int PHASES = 60;

    logic                    LS2CPU;
    logic                    rst;
    scsi_dp_pkg::xfer_mode_t mode;
    logic                    host_wr;
    logic [31:0]             host_wdata;
    logic                    f2s_full;
    logic                    f2s_empty;
    logic                    host_rd;
    logic [31:0]             host_rdata;
    logic                    s2f_empty;
    logic                    s2f_full;
    logic                    scsi_req;
    logic [7:0]              scsi_din;
    logic [7:0]              scsi_dout;
    logic                    scsi_dout_valid;
    logic                    scsi_oe;
    logic                    tx_ready;
    logic                    cpu_wr;
    logic [31:0]             cpu_wdata;
    logic                    a3;
    logic [31:0]             cpu_rdata;

    // model: bytes expected on scsi, msb lane of each word first
    logic [7:0]  byte_q [$];
    // model: words expected at host_rdata, oldest first
    logic [31:0] word_q [$];
    // model: last byte latched in s2cpu
    logic [7:0]  cpu_byte;
    int          err_count;
    int          sel;

    scsi_datapath #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) scsi_datapath_i (
        .LS2CPU          (LS2CPU),
        .rst             (rst),
        .mode            (mode),
        .host_wr         (host_wr),
        .host_wdata      (host_wdata),
        .f2s_full        (f2s_full),
        .f2s_empty       (f2s_empty),
        .host_rd         (host_rd),
        .host_rdata      (host_rdata),
        .s2f_empty       (s2f_empty),
        .s2f_full        (s2f_full),
        .scsi_req        (scsi_req),
        .scsi_din        (scsi_din),
        .scsi_dout       (scsi_dout),
        .scsi_dout_valid (scsi_dout_valid),
        .scsi_oe         (scsi_oe),
        .tx_ready        (tx_ready),
        .cpu_wr          (cpu_wr),
        .cpu_wdata       (cpu_wdata),
        .a3              (a3),
        .cpu_rdata       (cpu_rdata)
    );

    initial begin
        LS2CPU = 1'b0;
        forever #5 LS2CPU = ~LS2CPU;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            err_count++;
            $display("MISMATCH at time %0t: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            abort_run();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge LS2CPU);
    endtask

    task automatic wait_tx_ready();
        int n;
        n = 0;
        while (!tx_ready) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: tx_ready never rose within %0d cycles", WAIT_LIMIT);
                abort_run();
            end
            @(negedge LS2CPU);
            n++;
        end
    endtask

    task automatic wait_s2f_data();
        int n;
        n = 0;
        while (s2f_empty) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: s2f_empty never fell within %0d cycles", WAIT_LIMIT);
                abort_run();
            end
            @(negedge LS2CPU);
            n++;
        end
    endtask

    // host words go to the f2s fifo, skipped once it reports full
    task automatic write_words(input int count);
        logic [31:0] w;
        for (int i = 0; i < count; i++) begin
            if (!f2s_full) begin
                w          = $urandom;
                host_wr    = 1'b1;
                host_wdata = w;
                for (int l = 0; l < 4; l++) begin
                    byte_q.push_back(w[31-8*l -: 8]);
                end
                @(negedge LS2CPU);
                host_wr = 1'b0;
            end
        end
    endtask

    // new batch plus any words left by earlier phases, drained fully
    task automatic run_f2s();
        mode = scsi_dp_pkg::XM_F2S;
        write_words(1 + $urandom % FIFO_DEPTH);
        while (byte_q.size() > 0) begin
            idle_cycles($urandom % 3);
            wait_tx_ready();
            scsi_req = 1'b1;
            @(negedge LS2CPU);
            scsi_req = 1'b0;
            check(32'(scsi_dout_valid), 32'd1, "F2S byte strobe");
            check(32'(scsi_dout), 32'(byte_q.pop_front()), "F2S byte");
            check(32'(scsi_oe), 32'd1, "scsi_oe in F2S");
        end
    endtask

    task automatic run_s2f();
        logic [31:0] w;
        int          nwords;
        mode   = scsi_dp_pkg::XM_S2F;
        w      = '0;
        nwords = 1 + $urandom % FIFO_DEPTH;
        for (int i = 0; i < nwords; i++) begin
            check(32'(s2f_full), 32'd0, "s2f_full before a new word");
            // first byte of the word belongs in [31:24]
            for (int l = 0; l < 4; l++) begin
                idle_cycles($urandom % 3);
                scsi_din          = 8'($urandom);
                w[31-8*l -: 8]    = scsi_din;
                scsi_req          = 1'b1;
                @(negedge LS2CPU);
                scsi_req = 1'b0;
            end
            word_q.push_back(w);
        end
        // last word lands in the fifo one cycle after its push strobe
        @(negedge LS2CPU);
        check(32'(s2f_full), 32'(nwords == FIFO_DEPTH), "s2f_full after the last word");
        while (word_q.size() > 0) begin
            idle_cycles($urandom % 3);
            wait_s2f_data();
            check(host_rdata, word_q.pop_front(), "S2F word at host_rdata");
            host_rd = 1'b1;
            @(negedge LS2CPU);
            host_rd = 1'b0;
        end
        check(32'(s2f_empty), 32'd1, "s2f_empty after draining");
    endtask

    task automatic run_cpu2s();
        logic [31:0] w;
        logic        hi;
        mode = scsi_dp_pkg::XM_CPU2S;
        // words parked in the f2s fifo wait for the next F2S phase
        write_words($urandom % 2);
        repeat (1 + $urandom % 4) begin
            idle_cycles($urandom % 3);
            w         = $urandom;
            hi        = 1'($urandom);
            cpu_wdata = w;
            a3        = hi;
            cpu_wr    = 1'b1;
            @(negedge LS2CPU);
            cpu_wr = 1'b0;
            check(32'(scsi_dout_valid), 32'd1, "CPU2S byte strobe");
            check(32'(scsi_dout), hi ? 32'(w[23:16]) : 32'(w[7:0]), "CPU2S byte");
            check(32'(scsi_oe), 32'd1, "scsi_oe in CPU2S");
        end
    endtask

    task automatic run_s2cpu();
        mode = scsi_dp_pkg::XM_S2CPU;
        // latch keeps the last byte across other modes
        check(cpu_rdata, {cpu_byte, 8'h00, cpu_byte, 8'h00}, "cpu_rdata held");
        write_words($urandom % 2);
        repeat (1 + $urandom % 4) begin
            idle_cycles($urandom % 3);
            cpu_byte = 8'($urandom);
            scsi_din = cpu_byte;
            scsi_req = 1'b1;
            @(negedge LS2CPU);
            scsi_req = 1'b0;
            check(cpu_rdata, {cpu_byte, 8'h00, cpu_byte, 8'h00}, "S2CPU read pattern");
            check(32'(scsi_oe), 32'd0, "scsi_oe in S2CPU");
        end
    endtask

    task automatic run_idle();
        mode = scsi_dp_pkg::XM_IDLE;
        idle_cycles(1 + $urandom % 4);
        check(32'(scsi_oe), 32'd0, "scsi_oe in IDLE");
        check(32'(scsi_dout_valid), 32'd0, "no byte strobe in IDLE");
    endtask

    task automatic check_reset_state();
        check(32'(tx_ready), 32'd0, "tx_ready after reset");
        check(32'(scsi_dout_valid), 32'd0, "scsi_dout_valid after reset");
        check(32'(scsi_datapath_i.f2s_pop), 32'd0, "f2s_pop after reset");
        check(32'(scsi_datapath_i.s2f_push), 32'd0, "s2f_push after reset");
        check(32'(scsi_oe), 32'd0, "scsi_oe after reset");
        check(32'(f2s_full), 32'd0, "f2s_full after reset");
        check(32'(s2f_full), 32'd0, "s2f_full after reset");
        check(32'(f2s_empty), 32'd1, "f2s_empty after reset");
        check(32'(s2f_empty), 32'd1, "s2f_empty after reset");
        check(cpu_rdata, 32'd0, "cpu_rdata after reset");
    endtask

    initial begin
        void'($urandom(36784));
        rst        = 1'b1;
        mode       = scsi_dp_pkg::XM_IDLE;
        host_wr    = 1'b0;
        host_wdata = '0;
        host_rd    = 1'b0;
        scsi_req   = 1'b0;
        scsi_din   = '0;
        cpu_wr     = 1'b0;
        cpu_wdata  = '0;
        a3         = 1'b0;
        cpu_byte   = '0;
        err_count  = 0;
        repeat (8) @(negedge LS2CPU);
        check_reset_state();
        rst = 1'b0;
        @(negedge LS2CPU);
        // each mode once in order, then a random mix
        for (int p = 0; p < PHASES; p++) begin
            sel = (p < 5) ? p : int'($urandom % 5);
            case (sel)
                0: run_f2s();
                1: run_s2f();
                2: run_cpu2s();
                3: run_s2cpu();
                default: run_idle();
            endcase
        end
        // flush words parked by the non-F2S phases
        run_f2s();
        mode = scsi_dp_pkg::XM_IDLE;
        @(negedge LS2CPU);
        check(32'(byte_q.size()), 32'd0, "model byte queue drained");
        check(32'(word_q.size()), 32'd0, "model word queue drained");
        check(32'(f2s_empty), 32'd1, "f2s_empty at end");
        check(32'(s2f_empty), 32'd1, "s2f_empty at end");
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
design/scsi_dp_pkg.sv
design/dma_word_fifo.sv
design/scsi_byte_unpacker.sv
design/scsi_byte_packer.sv
design/scsi_datapath.sv
sim/tb_scsi_datapath.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= tb_scsi_datapath
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
